/* vgg_fc.f */
logic/fc_pkg.sv
logic/fc_input_loader.sv
logic/fc_pingpong_ram.sv
logic/fc_pe.sv
logic/fc_layer_ctrl.sv
logic/fc_result_reader.sv
logic/vgg_fc_top.sv
tests/tb_clock.sv
tests/fc_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = fc_tb
FILELIST = vgg_fc.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; st=$$?; cat $(LOG); \
	if [ $$st -ne 0 ] || grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/fc_tb.sv */
//////////////////////////////////////////////////
// fc engine testbench
//////////////////////////////////////////////////
module fc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_FRAMES     = 7;  // five small, two saturating
	localparam int SMALL_FRAMES   = 5;
	localparam int TIMEOUT_CYCLES = 3000 * NUM_FRAMES;
	localparam int IN_WORDS       = 4;
	localparam int L_FIN  [3]     = '{4, 3, 2};  // input words per layer
	localparam int L_FOUT [3]     = '{6, 4, 2};  // neurons per layer
	localparam int W_TOTAL        = L_FIN[0] * L_FOUT[0] + L_FIN[1] * L_FOUT[1]
	                              + L_FIN[2] * L_FOUT[2];

	logic        clk;
	logic        rstn;
	logic [31:0] in_data;
	logic        in_valid;
	logic        in_ready;
	logic [15:0] w_data;
	logic        w_valid;
	logic        w_ready;
	logic [31:0] out_data;
	logic        out_valid;
	logic        out_ready;
	logic        out_last;

	int          errors    = 0;
	int          checks    = 0;
	int          cycle_cnt = 0;
	logic [31:0] lcg_state = 32'hb475_bd70;

	// frame stimulus and model banks, [word][sample][lane]
	int          act_mem [IN_WORDS][2][2];
	int          wts [W_TOTAL][2];  // layer, neuron, word order
	int          bank_a [4][2][2];
	int          bank_b [4][2][2];
	logic [31:0] in_words [IN_WORDS];
	logic [31:0] exp_out [2];

	tb_clock u_clock
	(
		.clk  (clk),
		.rstn (rstn)
	);

	vgg_fc_top DUT
	(
		.clk       (clk),
		.rstn      (rstn),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.w_data    (w_data),
		.w_valid   (w_valid),
		.w_ready   (w_ready),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_last  (out_last)
	);

	//////////////////////////////////////////////////
	// random numbers and helpers
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] span;
		span = 32'(hi - lo + 1);
		return lo + int'((next_rand() >> 8) % span);  // low bits are weak
	endfunction

	function automatic logic chance(input int pct);
		return rand_range(0, 99) < pct;
	endfunction

	function automatic int quantize(input int acc);
		int q;
		q = acc >>> 4;  // drop fraction bits
		if (q > 127)
			q = 127;
		else if (q < -128)
			q = -128;
		return q;
	endfunction

	task automatic check_val(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("[FAIL] %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// frame build and reference model
	task automatic make_frame(input int mode);
		int lo;
		int hi;
		lo = (mode == 0) ? -64 : 1;  // big frames use positive data
		hi = (mode == 0) ? 63 : 127;
		for (int k = 0; k < IN_WORDS; k++)
			for (int s = 0; s < 2; s++)
				for (int l = 0; l < 2; l++)
				begin
					act_mem[k][s][l] = rand_range(lo, hi);
					in_words[k][(s*2+l)*8 +: 8] = 8'(act_mem[k][s][l]);
				end
		case (mode)
			0:
			begin
				lo = -4;
				hi = 3;
			end
			1:
			begin
				lo = 64;
				hi = 127;
			end
			default:
			begin
				lo = -127;  // sign flips each layer
				hi = -64;
			end
		endcase
		for (int i = 0; i < W_TOTAL; i++)
			for (int l = 0; l < 2; l++)
				wts[i][l] = rand_range(lo, hi);
	endtask

	task automatic run_model();
		int widx;
		int acc;
		int src;
		widx = 0;
		for (int k = 0; k < IN_WORDS; k++)
			for (int s = 0; s < 2; s++)
				for (int l = 0; l < 2; l++)
					bank_a[k][s][l] = act_mem[k][s][l];
		for (int ly = 0; ly < 3; ly++)
		begin
			for (int n = 0; n < L_FOUT[ly]; n++)
			begin
				for (int s = 0; s < 2; s++)
				begin
					acc = 0;
					for (int k = 0; k < L_FIN[ly]; k++)
						for (int l = 0; l < 2; l++)
						begin
							src = (ly == 1) ? bank_b[k][s][l] : bank_a[k][s][l];  // ping-pong
							acc += wts[widx + k][l] * src;
						end
					if (ly == 1)
						bank_a[n/2][s][n%2] = quantize(acc);
					else
						bank_b[n/2][s][n%2] = quantize(acc);
				end
				widx += L_FIN[ly];
			end
		end
		// word 1 still holds layer 1 neurons 2 and 3
		for (int w = 0; w < 2; w++)
			for (int s = 0; s < 2; s++)
				for (int l = 0; l < 2; l++)
					exp_out[w][(s*2+l)*8 +: 8] = 8'(bank_b[w][s][l]);
	endtask

	//////////////////////////////////////////////////
	// one frame through all three handshakes
	task automatic run_frame(input int f, input int mode);
		int          in_idx;
		int          w_idx;
		int          out_cnt;
		int          w_pct;
		logic        in_fire;
		logic        w_fire;
		logic        hold;
		logic [31:0] held_data;
		logic        held_last;
		make_frame(mode);
		run_model();
		in_idx  = 0;
		w_idx   = 0;
		out_cnt = 0;
		in_fire = 1'b0;
		w_fire  = 1'b0;
		hold    = 1'b0;
		w_pct   = (f % 2 == 0) ? 50 : 90;  // gappy weights on even frames
		while (out_cnt < 2)
		begin
			@(negedge clk);
			if (in_fire)
				in_idx++;
			if (w_fire)
				w_idx++;
			if (hold)  // stalled word must not move
			begin
				check_val($sformatf("frame %0d hold valid", f), 32'd1, 32'(out_valid));
				check_val($sformatf("frame %0d hold data", f), held_data, out_data);
				check_val($sformatf("frame %0d hold last", f), 32'(held_last), 32'(out_last));
			end
			// input side
			if (in_idx < IN_WORDS)
			begin
				in_valid = chance(75);
				in_data  = in_words[in_idx];
				in_fire  = in_valid && in_ready;
			end
			else
			begin
				in_valid = 1'b0;
				in_fire  = 1'b0;
				check_val($sformatf("frame %0d in_ready busy", f), 32'd0, 32'(in_ready));
			end
			// weight side
			if (w_idx < W_TOTAL)
			begin
				w_valid = chance(w_pct);
				w_data  = {8'(wts[w_idx][1]), 8'(wts[w_idx][0])};
				w_fire  = w_valid && w_ready;  // w_ready settled since posedge
			end
			else
			begin
				w_valid = 1'b0;
				w_fire  = 1'b0;
				check_val($sformatf("frame %0d w_ready done", f), 32'd0, 32'(w_ready));
			end
			// output side
			out_ready = chance(50);
			hold      = out_valid && !out_ready;
			held_data = out_data;
			held_last = out_last;
			if (out_valid && out_ready)
			begin
				check_val($sformatf("frame %0d word %0d", f, out_cnt), exp_out[out_cnt], out_data);
				check_val($sformatf("frame %0d last %0d", f, out_cnt), 32'(out_cnt == 1),
					32'(out_last));
				if (mode == 1)
					check_val($sformatf("frame %0d sat high", f), 32'h7f7f_7f7f, out_data);
				else if (mode == 2)
					check_val($sformatf("frame %0d sat low", f), 32'h8080_8080, out_data);
				out_cnt++;
			end
		end
		check_val($sformatf("frame %0d weights used", f), 32'(W_TOTAL), 32'(w_idx));
	endtask

	//////////////////////////////////////////////////
	// main sequence
	initial
	begin
		in_data   = '0;
		in_valid  = 1'b0;
		w_data    = '0;
		w_valid   = 1'b0;
		out_ready = 1'b0;
		@(negedge clk);
		check_val("reset in_ready", 32'd0, 32'(in_ready));
		check_val("reset out_last", 32'd0, 32'(out_last));
		wait (rstn);
		@(negedge clk);  // one edge after release
		check_val("idle in_ready", 32'd1, 32'(in_ready));
		check_val("idle out_valid", 32'd0, 32'(out_valid));
		check_val("idle w_ready", 32'd0, 32'(w_ready));
		for (int f = 0; f < NUM_FRAMES; f++)
			run_frame(f, (f < SMALL_FRAMES) ? 0 : f - SMALL_FRAMES + 1);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog
	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	initial
	begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout: engine did not finish all frames in %0d cycles", cycle_cnt);
		$display("checks %0d errors %0d", checks, errors);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* tests/tb_clock.sv */
//////////////////////////////////////////////////
// testbench clock and reset
//////////////////////////////////////////////////
module tb_clock
(
	output logic clk,
	output logic rstn
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 5;   // 10 ns clock
	localparam int RESET_CYCLES = 10;

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	initial
	begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;  // release away from the active edge
	end

endmodule

/* logic/vgg_fc_top.sv */
//////////////////////////////////////////////////
// fc inference engine top
//////////////////////////////////////////////////
module vgg_fc_top
(
	input  logic                clk,
	input  logic                rstn,
	input  fc_pkg::batch_word_t in_data,
	input  logic                in_valid,
	output logic                in_ready,
	input  fc_pkg::af_word_t    w_data,
	input  logic                w_valid,
	output logic                w_ready,
	output fc_pkg::batch_word_t out_data,
	output logic                out_valid,
	input  logic                out_ready,
	output logic                out_last
);

	// loader to bank a
	logic [fc_pkg::ADDR_W-1:0] ld_addr;
	logic                      ld_en;
	fc_pkg::batch_word_t       ld_data;
	logic                      frame_full;
	logic                      frame_done;

	// controller to banks
	logic [fc_pkg::ADDR_W-1:0]         rd_addr;
	logic                              rd_en;
	fc_pkg::batch_word_t               rd_data;
	logic [fc_pkg::ADDR_W-1:0]         wr_addr;
	logic                              wr_en;
	logic [fc_pkg::AF-1:0]             wr_lane;
	fc_pkg::lane_t [fc_pkg::BATCH-1:0] wr_sample_data;
	fc_pkg::layer_e                    layer;

	// reader
	logic [fc_pkg::ADDR_W-1:0] rs_addr;
	logic                      rs_en;
	fc_pkg::batch_word_t       rs_data;
	logic                      result_start;
	logic                      result_done;

	fc_input_loader u_loader
	(
		.clk        (clk),
		.rstn       (rstn),
		.in_data    (in_data),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.ld_addr    (ld_addr),
		.ld_en      (ld_en),
		.ld_data    (ld_data),
		.frame_full (frame_full),
		.frame_done (frame_done)
	);

	fc_pingpong_ram u_ram
	(
		.clk            (clk),
		.layer          (layer),
		.rd_addr        (rd_addr),
		.rd_en          (rd_en),
		.rd_data        (rd_data),
		.wr_addr        (wr_addr),
		.wr_en          (wr_en),
		.wr_lane        (wr_lane),
		.wr_sample_data (wr_sample_data),
		.ld_addr        (ld_addr),
		.ld_en          (ld_en),
		.ld_data        (ld_data),
		.rs_addr        (rs_addr),
		.rs_en          (rs_en),
		.rs_data        (rs_data)
	);

	fc_layer_ctrl u_ctrl
	(
		.clk            (clk),
		.rstn           (rstn),
		.frame_full     (frame_full),
		.frame_done     (frame_done),
		.w_data         (w_data),
		.w_valid        (w_valid),
		.w_ready        (w_ready),
		.rd_addr        (rd_addr),
		.rd_en          (rd_en),
		.rd_data        (rd_data),
		.wr_addr        (wr_addr),
		.wr_en          (wr_en),
		.wr_lane        (wr_lane),
		.wr_sample_data (wr_sample_data),
		.layer          (layer),
		.result_start   (result_start),
		.result_done    (result_done)
	);

	fc_result_reader u_reader
	(
		.clk          (clk),
		.rstn         (rstn),
		.result_start (result_start),
		.result_done  (result_done),
		.rs_addr      (rs_addr),
		.rs_en        (rs_en),
		.rs_data      (rs_data),
		.out_data     (out_data),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_last     (out_last)
	);

endmodule

/* logic/fc_result_reader.sv */
//////////////////////////////////////////////////
// result stream out of bank b
//////////////////////////////////////////////////
module fc_result_reader
(
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      result_start,
	output logic                      result_done,
	output logic [fc_pkg::ADDR_W-1:0] rs_addr,
	output logic                      rs_en,
	input  fc_pkg::batch_word_t       rs_data,
	output fc_pkg::batch_word_t       out_data,
	output logic                      out_valid,
	input  logic                      out_ready,
	output logic                      out_last
);

	logic                      xfer;
	logic                      pend;       // rs_data arrives this cycle
	logic [fc_pkg::ADDR_W-1:0] pend_addr;
	logic [fc_pkg::ADDR_W-1:0] out_addr;   // address now on out_data

	assign xfer    = out_valid && out_ready;
	assign rs_en   = result_start || (xfer && !out_last);  // next word after a transfer
	assign rs_addr = result_start ? '0 : out_addr + 1'b1;

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			pend        <= 1'b0;
			out_valid   <= 1'b0;
			out_last    <= 1'b0;
			result_done <= 1'b0;
		end
		else
		begin
			pend        <= rs_en;
			result_done <= xfer && out_last;  // whole frame gone
			if (pend)
			begin
				out_valid <= 1'b1;
				out_last  <= (pend_addr == fc_pkg::ADDR_W'(fc_pkg::OUT_WORDS - 1));
			end
			else if (xfer)
			begin
				out_valid <= 1'b0;
				out_last  <= 1'b0;
			end
		end
	end

	// payload
	always_ff @(posedge clk)
	begin
		if (rs_en)
			pend_addr <= rs_addr;
		if (pend)
		begin
			out_data <= rs_data;
			out_addr <= pend_addr;
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

/* logic/fc_layer_ctrl.sv */
//////////////////////////////////////////////////
// layer sequencer and pe array
//////////////////////////////////////////////////
module fc_layer_ctrl
(
	input  logic                              clk,
	input  logic                              rstn,
	input  logic                              frame_full,
	output logic                              frame_done,
	input  fc_pkg::af_word_t                  w_data,
	input  logic                              w_valid,
	output logic                              w_ready,
	output logic [fc_pkg::ADDR_W-1:0]         rd_addr,
	output logic                              rd_en,
	input  fc_pkg::batch_word_t               rd_data,
	output logic [fc_pkg::ADDR_W-1:0]         wr_addr,
	output logic                              wr_en,
	output logic [fc_pkg::AF-1:0]             wr_lane,
	output fc_pkg::lane_t [fc_pkg::BATCH-1:0] wr_sample_data,
	output fc_pkg::layer_e                    layer,
	output logic                              result_start,
	input  logic                              result_done
);

	fc_pkg::ctrl_state_e       state;
	logic [fc_pkg::ADDR_W-1:0] fin_max;   // words per neuron, this layer
	logic [fc_pkg::ADDR_W-1:0] fout_max;  // neurons, this layer
	logic [fc_pkg::ADDR_W-1:0] w_cnt;
	logic [fc_pkg::ADDR_W-1:0] neuron;
	logic [1:0]                drain_cnt;
	logic                      w_fire;
	fc_pkg::af_word_t          w_dly;     // lines up with rd_data
	logic                      pe_run;
	logic                      pe_clear;

	assign w_ready    = (state == fc_pkg::ACCUM) && (w_cnt < fin_max);
	assign w_fire     = w_valid && w_ready;
	assign rd_en      = w_fire;  // weight k pairs with word k
	assign rd_addr    = w_cnt;
	assign wr_en      = (state == fc_pkg::WRITE);
	assign wr_addr    = fc_pkg::ADDR_W'(neuron / fc_pkg::AF);
	assign frame_done = (state == fc_pkg::RESULT) && result_done;

	always_comb
	begin
		wr_lane = '0;
		wr_lane[neuron % fc_pkg::AF] = 1'b1;  // neuron n -> lane n mod af
	end

	//////////////////////////////////////////////////
	// state machine
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state        <= fc_pkg::IDLE;
			layer        <= fc_pkg::LAYER1;
			fin_max      <= '0;
			fout_max     <= '0;
			w_cnt        <= '0;
			neuron       <= '0;
			drain_cnt    <= '0;
			result_start <= 1'b0;
		end
		else
		begin
			result_start <= 1'b0;
			case (state)
				fc_pkg::IDLE:
				begin
					if (frame_full)
					begin
						layer  <= fc_pkg::LAYER1;
						neuron <= '0;
						state  <= fc_pkg::FETCH;
					end
				end
				fc_pkg::FETCH:  // layer sizes from table
				begin
					fin_max  <= fc_pkg::ADDR_W'(fc_pkg::FIN_WORDS[layer]);
					fout_max <= fc_pkg::ADDR_W'(fc_pkg::FOUT[layer]);
					state    <= fc_pkg::WAIT_WEIGHT;
				end
				fc_pkg::WAIT_WEIGHT:
				begin
					w_cnt <= '0;
					if (w_valid)
						state <= fc_pkg::ACCUM;
				end
				fc_pkg::ACCUM:  // stalls while w_valid low
				begin
					if (w_fire)
					begin
						w_cnt <= w_cnt + 1'b1;
						if (w_cnt == fin_max - 1'b1)
						begin
							drain_cnt <= '0;
							state     <= fc_pkg::DRAIN;
						end
					end
				end
				fc_pkg::DRAIN:  // last pair still in pe
				begin
					if (drain_cnt == 2'(fc_pkg::PE_LAT - 1))
						state <= fc_pkg::WRITE;
					else
						drain_cnt <= drain_cnt + 1'b1;
				end
				fc_pkg::WRITE:
					state <= fc_pkg::NEXT;
				fc_pkg::NEXT:
				begin
					if (neuron == fout_max - 1'b1)
					begin
						neuron <= '0;
						if (layer == fc_pkg::LAYER3)
						begin
							result_start <= 1'b1;
							state        <= fc_pkg::RESULT;
						end
						else
						begin
							// swap banks by moving on a layer
							layer <= (layer == fc_pkg::LAYER1) ? fc_pkg::LAYER2 : fc_pkg::LAYER3;
							state <= fc_pkg::FETCH;
						end
					end
					else
					begin
						neuron <= neuron + 1'b1;
						state  <= fc_pkg::WAIT_WEIGHT;
					end
				end
				fc_pkg::RESULT:  // reader owns bank b
				begin
					if (result_done)
						state <= fc_pkg::IDLE;
				end
				default:
					state <= fc_pkg::IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// pe feed, one cycle behind the handshake
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			pe_run   <= 1'b0;
			pe_clear <= 1'b0;
		end
		else
		begin
			pe_run   <= w_fire;
			pe_clear <= w_fire && (w_cnt == '0);  // first word of neuron
		end
	end

	always_ff @(posedge clk)
	begin
		if (w_fire)
			w_dly <= w_data;
	end

	for (genvar s = 0; s < fc_pkg::BATCH; s++)
	begin : g_pe
		fc_pe u_pe
		(
			.clk    (clk),
			.rstn   (rstn),
			.clear  (pe_clear),
			.run    (pe_run),
			.weight (w_dly),            // shared by all samples
			.data   (rd_data[s]),
			.result (wr_sample_data[s])
		);
	end

	// frame stays held by the loader while weights are pulled
	a_wready_accum: assert property (@(posedge clk) disable iff (!rstn)
		w_ready |-> (state == fc_pkg::ACCUM) && frame_full);

endmodule

/* logic/fc_pe.sv */
//////////////////////////////////////////////////
// mac with quantize
//////////////////////////////////////////////////
module fc_pe
(
	input  logic             clk,
	input  logic             rstn,
	input  logic             clear,
	input  logic             run,
	input  fc_pkg::af_word_t weight,
	input  fc_pkg::af_word_t data,
	output fc_pkg::lane_t    result
);

	logic signed [2*fc_pkg::DATA_W-1:0] prod [fc_pkg::AF];
	logic                               run_d;
	logic                               clear_d;
	logic signed [fc_pkg::ACC_W-1:0]    prod_sum;
	logic signed [fc_pkg::ACC_W-1:0]    acc;
	logic signed [fc_pkg::ACC_W-1:0]    acc_shift;

	// stage one, lane products
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < fc_pkg::AF; i++)
			prod[i] <= $signed(weight[i]) * $signed(data[i]);
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			run_d   <= 1'b0;
			clear_d <= 1'b0;
		end
		else
		begin
			run_d   <= run;
			clear_d <= clear;  // travels with its products
		end
	end

	always_comb
	begin
		prod_sum = '0;
		for (int i = 0; i < fc_pkg::AF; i++)
			prod_sum = prod_sum + fc_pkg::ACC_W'(prod[i]);  // sign extended
	end

	// stage two, accumulate
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			acc <= '0;
		else if (run_d)
			acc <= clear_d ? prod_sum : acc + prod_sum;  // clear starts a neuron
	end

	// drop fraction bits, clamp to one lane
	assign acc_shift = acc >>> fc_pkg::PRECISION;

	always_comb
	begin
		if (acc_shift > fc_pkg::LANE_MAX)
			result = fc_pkg::lane_t'(fc_pkg::LANE_MAX);
		else if (acc_shift < fc_pkg::LANE_MIN)
			result = fc_pkg::lane_t'(fc_pkg::LANE_MIN);
		else
			result = acc_shift[fc_pkg::DATA_W-1:0];
	end

endmodule

/* logic/fc_pingpong_ram.sv */
//////////////////////////////////////////////////
// ping-pong activation banks
//////////////////////////////////////////////////
module fc_pingpong_ram
(
	input  logic                                       clk,
	input  fc_pkg::layer_e                             layer,
	input  logic [fc_pkg::ADDR_W-1:0]                  rd_addr,
	input  logic                                       rd_en,
	output fc_pkg::batch_word_t                        rd_data,
	input  logic [fc_pkg::ADDR_W-1:0]                  wr_addr,
	input  logic                                       wr_en,
	input  logic [fc_pkg::AF-1:0]                      wr_lane,
	input  fc_pkg::lane_t [fc_pkg::BATCH-1:0]          wr_sample_data,
	input  logic [fc_pkg::ADDR_W-1:0]                  ld_addr,
	input  logic                                       ld_en,
	input  fc_pkg::batch_word_t                        ld_data,
	input  logic [fc_pkg::ADDR_W-1:0]                  rs_addr,
	input  logic                                       rs_en,
	output fc_pkg::batch_word_t                        rs_data
);

	fc_pkg::batch_word_t bank_a [fc_pkg::BANK_DEPTH];
	fc_pkg::batch_word_t bank_b [fc_pkg::BANK_DEPTH];

	logic                       b_is_src;  // layer 2 reads b, writes a
	logic [fc_pkg::BANK_AW-1:0] rd_idx;
	logic [fc_pkg::BANK_AW-1:0] wr_idx;
	logic [fc_pkg::BANK_AW-1:0] ld_idx;
	logic [fc_pkg::BANK_AW-1:0] rs_idx;

	assign b_is_src = (layer == fc_pkg::LAYER2);
	assign rd_idx   = rd_addr[fc_pkg::BANK_AW-1:0];
	assign wr_idx   = wr_addr[fc_pkg::BANK_AW-1:0];
	assign ld_idx   = ld_addr[fc_pkg::BANK_AW-1:0];
	assign rs_idx   = rs_addr[fc_pkg::BANK_AW-1:0];

	//////////////////////////////////////////////////
	// bank a: loader plus layer 2 results
	always_ff @(posedge clk)
	begin
		if (ld_en)
			bank_a[ld_idx] <= ld_data;
		if (wr_en && b_is_src)
		begin
			for (int s = 0; s < fc_pkg::BATCH; s++)
				for (int l = 0; l < fc_pkg::AF; l++)
					if (wr_lane[l])
						bank_a[wr_idx][s][l] <= wr_sample_data[s];  // one lane only
		end
	end

	// bank b: layer 1 and 3 results
	always_ff @(posedge clk)
	begin
		if (wr_en && !b_is_src)
		begin
			for (int s = 0; s < fc_pkg::BATCH; s++)
				for (int l = 0; l < fc_pkg::AF; l++)
					if (wr_lane[l])
						bank_b[wr_idx][s][l] <= wr_sample_data[s];
		end
	end

	//////////////////////////////////////////////////
	// registered reads, one cycle latency
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= b_is_src ? bank_b[rd_idx] : bank_a[rd_idx];
		if (rs_en)
			rs_data <= bank_b[rs_idx];  // readout always from b
	end

	// loader owns a only while the engine is idle
	a_bank_a_owner: assert property (@(posedge clk) !(ld_en && wr_en && b_is_src));

endmodule

/* logic/fc_input_loader.sv */
//////////////////////////////////////////////////
// input frame loader
//////////////////////////////////////////////////
module fc_input_loader
(
	input  logic                      clk,
	input  logic                      rstn,
	input  fc_pkg::batch_word_t       in_data,
	input  logic                      in_valid,
	output logic                      in_ready,
	output logic [fc_pkg::ADDR_W-1:0] ld_addr,
	output logic                      ld_en,
	output fc_pkg::batch_word_t       ld_data,
	output logic                      frame_full,
	input  logic                      frame_done
);

	logic [fc_pkg::ADDR_W-1:0] cnt;  // words taken this frame
	logic                      last_word;

	assign ld_en     = in_valid && in_ready;  // write on accept edge
	assign ld_addr   = cnt;
	assign ld_data   = in_data;
	assign last_word = (cnt == fc_pkg::ADDR_W'(fc_pkg::FIN_WORDS[0] - 1));

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			cnt        <= '0;
			frame_full <= 1'b0;
			in_ready   <= 1'b0;
		end
		else if (frame_done)
		begin
			// engine done with bank a
			cnt        <= '0;
			frame_full <= 1'b0;
			in_ready   <= 1'b1;
		end
		else if (ld_en)
		begin
			cnt <= cnt + 1'b1;
			if (last_word)
			begin
				frame_full <= 1'b1;  // hand frame over
				in_ready   <= 1'b0;
			end
		end
		else if (!frame_full)
		begin
			in_ready <= 1'b1;  // first cycle out of reset
		end
	end

endmodule

/* logic/fc_pkg.sv */
//////////////////////////////////////////////////
// fc engine shared definitions
//////////////////////////////////////////////////
package fc_pkg;

	// lane and accumulator sizes
	localparam int DATA_W    = 8;
	localparam int PRECISION = 4;   // fraction bits dropped on quantize
	localparam int ACC_W     = 24;
	localparam int LANE_MAX  = 2**(DATA_W-1) - 1;
	localparam int LANE_MIN  = -(2**(DATA_W-1));

	// array shape
	localparam int BATCH      = 2;  // samples side by side
	localparam int AF         = 2;  // lanes per word
	localparam int NUM_LAYERS = 3;

	// per layer table, index by layer_e
	localparam int FIN_WORDS [NUM_LAYERS] = '{4, 3, 2};  // input words
	localparam int FOUT      [NUM_LAYERS] = '{6, 4, 2};  // output neurons

	// banks and pipeline
	localparam int ADDR_W     = 3;
	localparam int BANK_DEPTH = 4;
	localparam int BANK_AW    = $clog2(BANK_DEPTH);
	localparam int OUT_WORDS  = 2;  // bank b words streamed out
	localparam int PE_LAT     = 2;  // operands to accumulator

	typedef logic signed [DATA_W-1:0] lane_t;
	typedef lane_t [AF-1:0] af_word_t;           // weight word, one sample
	typedef af_word_t [BATCH-1:0] batch_word_t;  // one bank word

	// layer 2 is the only one reading b
	typedef enum logic [1:0] {LAYER1, LAYER2, LAYER3} layer_e;

	typedef enum logic [2:0]
	{
		IDLE, WAIT_WEIGHT, FETCH, ACCUM, DRAIN, WRITE, NEXT, RESULT
	} ctrl_state_e;

endpackage
